// ==== reg_mgr_pkg.sv ====
package reg_mgr_pkg;

  // word and address widths
  localparam int DATA_W    = 32;
  localparam int ADDR_W    = 32;
  // operand field register number
  localparam int REG_NUM_W = 4;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;

  // controller request for one operand
  typedef enum logic [2:0] {
    op_idle      = 3'd0,
    op_catch     = 3'd1,
    op_read      = 3'd2,
    op_read_ptr  = 3'd3,
    op_write     = 3'd4,
    op_write_ptr = 3'd5
  } reg_op_e;

  // post modify flags from the instruction word
  typedef enum logic [1:0] {
    mod_none     = 2'b00,
    mod_inc      = 2'b01,
    mod_dec      = 2'b10,
    // both bits set acts like no modify
    mod_none_alt = 2'b11
  } post_mod_e;

  // bus sequencer progress
  typedef enum logic [1:0] {
    step_idle  = 2'd0,
    step_issue = 2'd1,
    step_wait  = 2'd2,
    step_done  = 2'd3
  } seq_step_e;

  // decoded operand field, 7 bits
  typedef struct packed {
    logic [REG_NUM_W-1:0] reg_num;
    logic                 is_ptr;
    post_mod_e            post_mod;
  } operand_t;

  // outgoing shared bus request, 66 bits
  typedef struct packed {
    logic  read_q;
    logic  write_q;
    addr_t addr;
    data_t data;
  } bus_req_t;

  // shared bus completion, 67 bits
  typedef struct packed {
    logic  busy;
    logic  read_dn;
    logic  write_dn;
    addr_t addr;
    data_t data;
  } bus_rsp_t;

endpackage

// ==== operand_regs.sv ====
`timescale 1ns/100ps

module operand_regs (
  input  logic                  clk,
  input  logic                  rst,
  input  reg_mgr_pkg::reg_op_e  op,
  input  reg_mgr_pkg::operand_t operand,
  input  logic                  from_alu,
  input  reg_mgr_pkg::data_t    alu_data,
  input  reg_mgr_pkg::data_t    ptr_data,
  input  logic                  load_both,
  input  logic                  load_reg,
  input  reg_mgr_pkg::data_t    load_data,
  output logic                  catch_done,
  output reg_mgr_pkg::data_t    reg_value,
  output reg_mgr_pkg::data_t    ptr_value,
  output reg_mgr_pkg::data_t    write_value,
  output logic                  reg_valid,
  output logic                  ptr_valid
);
  import reg_mgr_pkg::*;

  // operand storage
  data_t reg_r;
  data_t ptr_r;

  // catch happens once per catch op
  logic  caught;
  logic  catch_now;

  // value picked for write back, before and after post modify
  data_t stored_value;
  data_t mod_value;

  assign catch_now = (op == op_catch) && !caught;

  // pointer operand writes back its pointer, plain operand its register
  assign stored_value = operand.is_ptr ? ptr_r : reg_r;

  always_comb begin
    case (operand.post_mod)
      mod_inc: mod_value = stored_value + data_t'(1);
      mod_dec: mod_value = stored_value - data_t'(1);
      // none and the spare code
      default: mod_value = stored_value;
    endcase
  end

  // indirect write stores the register unmodified
  assign write_value = (op == op_write_ptr) ? reg_r : mod_value;

  assign reg_value = reg_r;
  assign ptr_value = mod_value;

  always_ff @(posedge clk) begin
    if (rst) begin
      reg_r      <= '0;
      ptr_r      <= '0;
      caught     <= 1'b0;
      catch_done <= 1'b0;
      reg_valid  <= 1'b0;
      ptr_valid  <= 1'b0;
    end else begin
      // one cycle pulse back to the controller
      catch_done <= catch_now;

      // rearm as soon as op moves away from catch
      if (op != op_catch) begin
        caught <= 1'b0;
      end

      if (catch_now) begin
        caught    <= 1'b1;
        reg_valid <= 1'b1;
        if (from_alu) begin
          // alu result goes to the register only
          reg_r <= alu_data;
        end else begin
          reg_r     <= ptr_data;
          ptr_r     <= ptr_data;
          ptr_valid <= 1'b1;
        end
      end

      // direct read fills both copies
      if (load_both) begin
        reg_r     <= load_data;
        ptr_r     <= load_data;
        reg_valid <= 1'b1;
      end

      // indirect read replaces the register, pointer kept
      if (load_reg) begin
        reg_r     <= load_data;
        ptr_valid <= 1'b1;
      end
    end
  end

endmodule

// ==== bus_sequencer.sv ====
`timescale 1ns/100ps

module bus_sequencer (
  input  logic                  clk,
  input  logic                  rst,
  input  reg_mgr_pkg::reg_op_e  op,
  input  reg_mgr_pkg::operand_t operand,
  input  reg_mgr_pkg::addr_t    base_addr,
  input  logic                  grant,
  input  reg_mgr_pkg::data_t    ptr_value,
  input  reg_mgr_pkg::data_t    write_value,
  input  logic                  catch_done,
  input  reg_mgr_pkg::bus_rsp_t bus_rsp,
  output reg_mgr_pkg::bus_req_t bus_req,
  output logic                  load_both,
  output logic                  load_reg,
  output reg_mgr_pkg::data_t    load_data,
  output logic                  done
);
  import reg_mgr_pkg::*;

  seq_step_e step;

  // one request per grant period
  logic      armed;

  // request registers, held until next issue
  logic      read_q_r;
  logic      write_q_r;
  addr_t     addr_r;
  data_t     data_r;

  logic      done_r;

  // op decode
  logic      is_read_op;
  logic      is_write_op;
  logic      is_bus_op;
  logic      use_ptr;

  addr_t     target_addr;
  logic      start;
  logic      rsp_type_ok;
  logic      rsp_match;

  always_comb begin
    is_read_op  = (op == op_read) || (op == op_read_ptr);
    is_write_op = (op == op_write) || (op == op_write_ptr);
    is_bus_op   = is_read_op || is_write_op;
    use_ptr     = (op == op_read_ptr) || (op == op_write_ptr);
  end

  // direct access uses reg number as offset, indirect the pointer
  always_comb begin
    if (use_ptr) begin
      target_addr = base_addr + ptr_value;
    end else begin
      target_addr = base_addr + addr_t'(operand.reg_num);
    end
  end

  // issue only in idle, with grant, armed and a quiet bus
  assign start = (step == step_idle) && is_bus_op && grant && armed && !bus_rsp.busy;

  // completion kind must fit the request
  assign rsp_type_ok = is_read_op ? bus_rsp.read_dn : bus_rsp.write_dn;

  // foreign completions fail the address compare
  assign rsp_match = (step == step_wait) && bus_rsp.busy && rsp_type_ok &&
                     (bus_rsp.addr == addr_r);

  // loads go straight to storage so data lands with done
  assign load_both = rsp_match && (op == op_read);
  assign load_reg  = rsp_match && (op == op_read_ptr);
  assign load_data = bus_rsp.data;

  always_ff @(posedge clk) begin
    if (rst) begin
      armed <= 1'b0;
    end else if (!grant) begin
      // a grant gap permits the next request
      armed <= 1'b1;
    end else if (start) begin
      armed <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      step      <= step_idle;
      read_q_r  <= 1'b0;
      write_q_r <= 1'b0;
      addr_r    <= '0;
      data_r    <= '0;
      done_r    <= 1'b0;
    end else begin
      // strobes and done are single cycle
      read_q_r  <= 1'b0;
      write_q_r <= 1'b0;
      done_r    <= 1'b0;

      case (step)
        step_idle: begin
          if (start) begin
            read_q_r  <= is_read_op;
            write_q_r <= is_write_op;
            addr_r    <= target_addr;
            // reads carry no payload
            data_r    <= is_write_op ? write_value : '0;
            step      <= step_issue;
          end
        end

        step_issue: begin
          // strobe is on the bus this cycle
          step <= step_wait;
        end

        step_wait: begin
          if (rsp_match) begin
            done_r <= 1'b1;
            step   <= step_done;
          end
        end

        step_done: begin
          // stay until controller drops the bus op
          if (!is_bus_op) begin
            step <= step_idle;
          end
        end

        default: begin
          step <= step_idle;
        end
      endcase
    end
  end

  // bus outputs silent without grant
  always_comb begin
    if (grant) begin
      bus_req.read_q  = read_q_r;
      bus_req.write_q = write_q_r;
      bus_req.addr    = addr_r;
      bus_req.data    = data_r;
    end else begin
      bus_req = '0;
    end
  end

  // catch and bus completions share the done line
  assign done = done_r | catch_done;

endmodule

// ==== reg_manager.sv ====
`timescale 1ns/100ps

module reg_manager (
  input  logic                  clk,
  input  logic                  rst,
  input  reg_mgr_pkg::reg_op_e  op,
  input  reg_mgr_pkg::operand_t operand,
  input  reg_mgr_pkg::addr_t    base_addr,
  input  logic                  grant,
  input  logic                  from_alu,
  input  reg_mgr_pkg::data_t    alu_data,
  input  reg_mgr_pkg::data_t    ptr_data,
  input  reg_mgr_pkg::bus_rsp_t bus_rsp,
  output reg_mgr_pkg::bus_req_t bus_req,
  output logic                  done,
  output reg_mgr_pkg::data_t    reg_value,
  output reg_mgr_pkg::data_t    ptr_value,
  output logic                  reg_valid,
  output logic                  ptr_valid
);
  import reg_mgr_pkg::*;

  // sequencer to storage
  logic  load_both;
  logic  load_reg;
  data_t load_data;

  // storage to sequencer
  logic  catch_done;
  data_t write_value;

  // register and pointer storage
  operand_regs u_operand_regs (
    .clk         (clk),
    .rst         (rst),
    .op          (op),
    .operand     (operand),
    .from_alu    (from_alu),
    .alu_data    (alu_data),
    .ptr_data    (ptr_data),
    .load_both   (load_both),
    .load_reg    (load_reg),
    .load_data   (load_data),
    .catch_done  (catch_done),
    .reg_value   (reg_value),
    .ptr_value   (ptr_value),
    .write_value (write_value),
    .reg_valid   (reg_valid),
    .ptr_valid   (ptr_valid)
  );

  // shared bus requests and completions
  bus_sequencer u_bus_sequencer (
    .clk         (clk),
    .rst         (rst),
    .op          (op),
    .operand     (operand),
    .base_addr   (base_addr),
    .grant       (grant),
    .ptr_value   (ptr_value),
    .write_value (write_value),
    .catch_done  (catch_done),
    .bus_rsp     (bus_rsp),
    .bus_req     (bus_req),
    .load_both   (load_both),
    .load_reg    (load_reg),
    .load_data   (load_data),
    .done        (done)
  );

endmodule

// ==== tb_bus_memory.sv ====
`timescale 1ns/100ps

module tb_bus_memory (
  input  logic                  clk,
  input  logic                  rst,
  input  reg_mgr_pkg::bus_req_t bus_req,
  output reg_mgr_pkg::bus_rsp_t bus_rsp,
  output reg_mgr_pkg::addr_t    last_wr_addr,
  output reg_mgr_pkg::data_t    last_wr_data
);
  import reg_mgr_pkg::*;

  // 64 words, low address bits select
  data_t       mem [0:63];
  logic [31:0] lfsr;

  // start contents, every address bit changes the word
  function automatic data_t fill_word(input int i);
    return 32'hc0de_0000 ^ (data_t'(i) * 32'h0001_0007) ^ (data_t'(i) << 26);
  endfunction

  // galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // one lfsr step per bit taken
  task automatic take_bits(input int n, output int val);
    val = 0;
    for (int k = 0; k < n; k++) begin
      val  = (val << 1) | int'(lfsr[0]);
      lfsr = lfsr_next(lfsr);
    end
  endtask

  initial begin
    int    delay;
    int    foreign;
    int    idx;
    logic  is_rd;
    addr_t req_addr;
    data_t req_data;
    lfsr         = 32'h6deb5045;
    bus_rsp      = '0;
    last_wr_addr = '0;
    last_wr_data = '0;
    for (int i = 0; i < 64; i++) begin
      mem[i] = fill_word(i);
    end
    forever begin
      // strobe sampled mid cycle
      @(negedge clk);
      if (!rst && (bus_req.read_q || bus_req.write_q)) begin
        is_rd    = bus_req.read_q;
        req_addr = bus_req.addr;
        req_data = bus_req.data;
        idx      = int'(req_addr[5:0]);
        take_bits(3, delay);
        take_bits(1, foreign);
        // earliest answer is one cycle after the strobe
        @(negedge clk);
        for (int d = 0; d < delay; d++) begin
          @(negedge clk);
        end
        if (foreign != 0) begin
          // stray completion for another requester
          bus_rsp.busy     = 1'b1;
          bus_rsp.read_dn  = is_rd;
          bus_rsp.write_dn = !is_rd;
          bus_rsp.addr     = req_addr + 32'h100;
          bus_rsp.data     = ~mem[idx];
          @(negedge clk);
        end
        if (!is_rd) begin
          mem[idx]     = req_data;
          last_wr_addr = req_addr;
          last_wr_data = req_data;
        end
        bus_rsp.busy     = 1'b1;
        bus_rsp.read_dn  = is_rd;
        bus_rsp.write_dn = !is_rd;
        bus_rsp.addr     = req_addr;
        bus_rsp.data     = is_rd ? mem[idx] : req_data;
        @(negedge clk);
        bus_rsp = '0;
      end
    end
  end

endmodule

// ==== tb_reg_manager.sv ====
`timescale 1ns/100ps

module tb_reg_manager;
  import reg_mgr_pkg::*;

  logic     clk;
  logic     rst;
  reg_op_e  op;
  operand_t operand;
  addr_t    base_addr;
  logic     grant;
  logic     from_alu;
  data_t    alu_data;
  data_t    ptr_data;
  bus_rsp_t bus_rsp;
  bus_req_t bus_req;
  logic     done;
  data_t    reg_value;
  data_t    ptr_value;
  logic     reg_valid;
  logic     ptr_valid;
  addr_t    last_wr_addr;
  data_t    last_wr_data;

  // reference memory and operand copy
  data_t    ref_mem [0:63];
  data_t    ref_reg;
  data_t    ref_ptr;

  // expected at the next done pulse
  data_t    exp_reg_value;
  data_t    exp_ptr_value;
  logic     exp_reg_valid;
  logic     exp_ptr_valid;
  logic     exp_check_wr;
  addr_t    exp_wr_addr;
  data_t    exp_wr_data;

  int       stim_errors;
  int       cmp_errors;
  int       done_checks;
  int       ops_run;

  reg_manager u_reg_manager (.*);

  // answers strobes with random latency
  tb_bus_memory u_bus_memory (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  // same start contents as the memory model
  function automatic data_t init_word(input int i);
    return 32'hc0de_0000 ^ (data_t'(i) * 32'h0001_0007) ^ (data_t'(i) << 26);
  endfunction

  function automatic data_t apply_post_mod(input data_t v, input post_mod_e m);
    case (m)
      mod_inc: return v + 32'd1;
      mod_dec: return v - 32'd1;
      default: return v;
    endcase
  endfunction

  function automatic int word_index(input addr_t a);
    return int'(a[5:0]);
  endfunction

  function automatic operand_t make_operand(input int r, input logic p, input post_mod_e m);
    operand_t o;
    o.reg_num  = r[3:0];
    o.is_ptr   = p;
    o.post_mod = m;
    return o;
  endfunction

  task automatic show_mismatch(input string name, input logic [65:0] got,
                               input logic [65:0] exp, inout int count);
    $display("Mismatch %s: got %0h expected %0h at %0t", name, got, exp, $time);
    count++;
  endtask

  // steps the reference model through one op, sets what done must show
  function automatic void predict(input reg_op_e o, input operand_t opd, input addr_t base,
                                  input logic alu_sel, input data_t alu_word,
                                  input data_t ptr_word);
    addr_t a;
    exp_check_wr = 1'b0;
    case (o)
      op_read: begin
        a             = base + addr_t'(opd.reg_num);
        ref_reg       = ref_mem[word_index(a)];
        ref_ptr       = ref_reg;
        exp_reg_valid = 1'b1;
      end
      op_read_ptr: begin
        a             = base + ref_ptr;
        ref_reg       = ref_mem[word_index(a)];
        exp_ptr_valid = 1'b1;
      end
      op_write, op_write_ptr: begin
        if (o == op_write) begin
          exp_wr_addr = base + addr_t'(opd.reg_num);
          exp_wr_data = apply_post_mod(opd.is_ptr ? ref_ptr : ref_reg, opd.post_mod);
        end else begin
          // indirect write stores the plain register
          exp_wr_addr = base + ref_ptr;
          exp_wr_data = ref_reg;
        end
        ref_mem[word_index(exp_wr_addr)] = exp_wr_data;
        exp_check_wr = 1'b1;
      end
      op_catch: begin
        ref_reg       = alu_sel ? alu_word : ptr_word;
        ref_ptr       = alu_sel ? ref_ptr : ptr_word;
        exp_reg_valid = 1'b1;
        exp_ptr_valid = exp_ptr_valid | !alu_sel;
      end
      default: begin
        // idle leaves the model as it is
      end
    endcase
    exp_reg_value = ref_reg;
    exp_ptr_value = apply_post_mod(opd.is_ptr ? ref_ptr : ref_reg, opd.post_mod);
  endfunction

  // one controller op; op held hold cycles past done, then idle
  task automatic run_op(input reg_op_e o, input operand_t opd, input addr_t base,
                        input logic alu_sel, input data_t alu_word, input data_t ptr_word,
                        input int hold);
    int   cycles;
    int   extra;
    logic seen;
    predict(o, opd, base, alu_sel, alu_word, ptr_word);
    ops_run++;
    // grant gap arms the sequencer
    @(negedge clk);
    grant = 1'b0;
    op    = op_idle;
    @(negedge clk);
    grant     = 1'b1;
    op        = o;
    operand   = opd;
    base_addr = base;
    from_alu  = alu_sel;
    alu_data  = alu_word;
    ptr_data  = ptr_word;
    cycles    = 0;
    seen      = 1'b0;
    while (!seen && cycles < 200) begin
      @(negedge clk);
      cycles++;
      seen = done;
    end
    if (!seen) begin
      $display("Timeout: no done pulse within 200 cycles for %s", o.name());
      stim_errors++;
    end else if (o == op_catch && cycles != 1) begin
      $display("catch done came %0d cycles after op_catch instead of 1", cycles);
      stim_errors++;
    end
    extra = 0;
    for (int i = 0; i < hold + 2; i++) begin
      if (i == hold) begin
        op = op_idle;
      end
      @(negedge clk);
      if (done) begin
        extra++;
      end
    end
    if (extra != 0) begin
      $display("%0d extra done pulses after %s", extra, o.name());
      stim_errors++;
    end
  endtask

  // every done pulse against the reference
  always @(negedge clk) begin
    if (!rst && done) begin
      done_checks++;
      if (reg_value !== exp_reg_value)
        show_mismatch("reg_value", 66'(reg_value), 66'(exp_reg_value), cmp_errors);
      if (ptr_value !== exp_ptr_value)
        show_mismatch("ptr_value", 66'(ptr_value), 66'(exp_ptr_value), cmp_errors);
      if (reg_valid !== exp_reg_valid)
        show_mismatch("reg_valid", 66'(reg_valid), 66'(exp_reg_valid), cmp_errors);
      if (ptr_valid !== exp_ptr_valid)
        show_mismatch("ptr_valid", 66'(ptr_valid), 66'(exp_ptr_valid), cmp_errors);
      // memory side of a write
      if (exp_check_wr && last_wr_addr !== exp_wr_addr)
        show_mismatch("bus_req.addr", 66'(last_wr_addr), 66'(exp_wr_addr), cmp_errors);
      if (exp_check_wr && last_wr_data !== exp_wr_data)
        show_mismatch("bus_req.data", 66'(last_wr_data), 66'(exp_wr_data), cmp_errors);
    end
  end

  initial begin
    stim_errors   = 0;
    cmp_errors    = 0;
    done_checks   = 0;
    ops_run       = 0;
    rst           = 1'b1;
    op            = op_idle;
    operand       = '0;
    base_addr     = '0;
    grant         = 1'b1;
    from_alu      = 1'b0;
    alu_data      = '0;
    ptr_data      = '0;
    ref_reg       = '0;
    ref_ptr       = '0;
    exp_reg_valid = 1'b0;
    exp_ptr_valid = 1'b0;
    exp_check_wr  = 1'b0;
    for (int i = 0; i < 64; i++) begin
      ref_mem[i] = init_word(i);
    end
    repeat (16) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    // all cleared out of reset
    if (bus_req !== '0)
      show_mismatch("bus_req", 66'(bus_req), '0, stim_errors);
    if (done !== 1'b0)
      show_mismatch("done", 66'(done), '0, stim_errors);
    if (reg_value !== '0)
      show_mismatch("reg_value", 66'(reg_value), '0, stim_errors);
    if (ptr_value !== '0)
      show_mismatch("ptr_value", 66'(ptr_value), '0, stim_errors);
    if (reg_valid !== 1'b0 || ptr_valid !== 1'b0)
      show_mismatch("reg_valid/ptr_valid", 66'({reg_valid, ptr_valid}), '0, stim_errors);
    // grant high since reset, sequencer not armed yet
    op        = op_read;
    operand   = make_operand(3, 1'b0, mod_none);
    base_addr = 32'd8;
    repeat (6) begin
      @(negedge clk);
      if (bus_req !== '0)
        show_mismatch("bus_req", 66'(bus_req), '0, stim_errors);
    end
    op = op_idle;
    // direct reads
    run_op(op_read, make_operand(3, 1'b0, mod_none), 32'd8, 1'b0, '0, '0, 0);
    // no grant, quiet bus for any op while a request address is held
    grant = 1'b0;
    for (int i = 0; i < 8; i++) begin
      op = (i < 4) ? op_write : op_read_ptr;
      @(negedge clk);
      if (bus_req !== '0)
        show_mismatch("bus_req", 66'(bus_req), '0, stim_errors);
    end
    op = op_idle;
    run_op(op_read, make_operand(15, 1'b0, mod_none), 32'd40, 1'b0, '0, '0, 0);
    // indirect through the loaded pointer
    run_op(op_read_ptr, make_operand(15, 1'b1, mod_none), 32'd4, 1'b0, '0, '0, 0);
    // register and pointer differ here
    run_op(op_write_ptr, make_operand(0, 1'b1, mod_none), 32'd12, 1'b0, '0, '0, 0);
    // direct writes, each modifier
    run_op(op_write, make_operand(2, 1'b0, mod_inc), 32'd16, 1'b0, '0, '0, 0);
    run_op(op_write, make_operand(5, 1'b1, mod_dec), 32'd16, 1'b0, '0, '0, 0);
    run_op(op_write, make_operand(7, 1'b0, mod_none), 32'd16, 1'b0, '0, '0, 0);
    run_op(op_write, make_operand(9, 1'b1, mod_none_alt), 32'd16, 1'b0, '0, '0, 0);
    // read back the incremented word
    run_op(op_read, make_operand(2, 1'b0, mod_none), 32'd16, 1'b0, '0, '0, 0);
    // catches held past done, one pulse each
    run_op(op_catch, make_operand(1, 1'b1, mod_none), '0, 1'b1, 32'h1234_abcd,
           32'h0bad_f00d, 2);
    run_op(op_catch, make_operand(1, 1'b1, mod_none), '0, 1'b0, 32'h5555_0001,
           32'h0000_0021, 2);
    run_op(op_read_ptr, make_operand(0, 1'b1, mod_none), 32'd0, 1'b0, '0, '0, 0);
    repeat (2) @(negedge clk);
    if (done_checks != ops_run) begin
      $display("%0d done pulses checked for %0d operations", done_checks, ops_run);
      stim_errors++;
    end
    $display("error counts: stimulus %0d, compare %0d", stim_errors, cmp_errors);
    if (stim_errors == 0 && cmp_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== files.f ====
reg_mgr_pkg.sv
operand_regs.sv
bus_sequencer.sv
reg_manager.sv
tb_bus_memory.sv
tb_reg_manager.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator; the log decides the result
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_reg_manager -f files.f -o sim_reg_manager \
  && ./obj_dir/sim_reg_manager > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "Test passed" sim.log || { echo "no pass message in sim.log"; exit 1; }
exit 0
